//--- Bender.yml
package:
  name: simple_ipod

sources:
  # Playback core
  - files:
      - verilog/ipod_pkg.sv
      - verilog/kbd_command_decode.sv
      - verilog/speed_control.sv
      - verilog/flash_playback.sv
      - verilog/player_outputs.sv
      - verilog/simple_ipod_top.sv

  # Testbench, top module ipod_tb
  - target: test
    files:
      - bench/ipod_tb_clock.sv
      - bench/ipod_assertions.sv
      - bench/ipod_tb.sv

//--- bench/ipod_assertions.sv
`timescale 1ns/1ps

module ipod_assertions
  import ipod_pkg::*;
(
  input logic        CLK_50M,
  input logic        speed_reset_event,
  input play_state_e state,
  input play_mode_t  mode,
  input logic        restart,
  input flash_req_t  flash_req,
  input flash_rsp_t  flash_rsp
);

  int unsigned failures = 0;
  logic        outstanding;

  // Accepted read still waiting for its data
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      outstanding <= 1'b0;
    else if (flash_req.read && !flash_rsp.waitrequest)
      outstanding <= 1'b1;
    else if (flash_rsp.readdatavalid)
      outstanding <= 1'b0;
  end

  // ==================================================================
  // Flash handshake
  // ==================================================================

  address_held: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
  else
  begin
    $error("Read dropped or address moved while waitrequest was high");
    failures++;
  end

  single_read: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    outstanding |-> !flash_req.read)
  else
  begin
    $error("New read started while one was outstanding");
    failures++;
  end

  // ==================================================================
  // Playback control
  // ==================================================================

  // Paused playback keeps its place in the word
  no_load_paused: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    !mode.playing && !restart && state inside {PS_FIRST_HALF, PS_SECOND_HALF}
    |=> state == $past(state))
  else
  begin
    $error("Playback moved on to another sample while paused");
    failures++;
  end

  state_legal: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    state inside {PS_IDLE, PS_REQUEST, PS_WAIT_DATA, PS_FIRST_HALF, PS_SECOND_HALF})
  else
  begin
    $error("Playback FSM left its state set");
    failures++;
  end

endmodule

bind flash_playback ipod_assertions i_ipod_assertions (
  .CLK_50M           (CLK_50M),
  .speed_reset_event (speed_reset_event),
  .state             (state),
  .mode              (mode),
  .restart           (restart),
  .flash_req         (flash_req),
  .flash_rsp         (flash_rsp)
);

//--- bench/ipod_tb.sv
`timescale 1ns/1ps

module ipod_tb
  import ipod_pkg::*;
();

  localparam flash_addr_t ADDR_LAST       = 23'd7;
  localparam divisor_t    DEFAULT_DIVISOR = 16'd40;
  localparam divisor_t    MIN_DIVISOR     = 16'd4;
  localparam int          REPEAT_CYCLES   = 16;

  // Samples checked per step
  localparam int N_FWD    = 20;
  localparam int N_BWD    = 20;
  localparam int N_RESUME = 8;
  localparam int N_LOWER  = 6;
  localparam int N_JUNK   = 6;

  localparam int QUIET_CYCLES   = 200;
  localparam int SAMPLE_CYCLES  = 80;
  localparam int SPEED_WRAPS    = 5 + 40 + 3;
  localparam int BUDGET_CYCLES  = (N_FWD + N_BWD + N_RESUME + N_LOWER + N_JUNK) * SAMPLE_CYCLES
                                + 2 * QUIET_CYCLES + SPEED_WRAPS * REPEAT_CYCLES + 400;
  localparam int TIMEOUT_CYCLES = 2 * BUDGET_CYCLES;

  // Lit segments for 0 to F with segment a in bit 0
  localparam logic [6:0] SEG_LIT [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D,
    7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

  logic        CLK_50M;
  logic        power_on_reset;
  logic        reset_pulse;
  logic        speed_reset_event;
  ascii_t      ascii;
  logic        ascii_valid;
  logic        speed_up;
  logic        speed_down;
  flash_req_t  flash_req;
  flash_rsp_t  flash_rsp = '{waitrequest: 1'b1, readdatavalid: 1'b0, readdata: '0};
  sample_t     sample;
  ascii_t      audio_out;
  logic        sample_valid;
  seg7_t       hex0;
  seg7_t       hex1;
  seg7_t       hex2;
  seg7_t       hex3;

  // Flash model state
  logic [31:0] lcg_state = 32'hf50990ac;
  logic        flash_busy = 1'b0;
  int          stall_left = 0;
  int          latency_left = 0;
  flash_addr_t pending_addr = '0;

  // Expected sequence
  logic        quiet;
  flash_addr_t seq_start;
  logic        seq_backward;
  int          seq_index;
  divisor_t    model_divisor;
  int          cycle_count = 0;

  assign speed_reset_event = power_on_reset | reset_pulse;

  ipod_tb_clock #(
    .RESET_CYCLES (8)
  ) i_ipod_tb_clock (
    .CLK_50M        (CLK_50M),
    .power_on_reset (power_on_reset)
  );

  simple_ipod_top #(
    .ADDR_LAST       (ADDR_LAST),
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR),
    .MIN_DIVISOR     (MIN_DIVISOR),
    .REPEAT_CYCLES   (REPEAT_CYCLES)
  ) i_simple_ipod_top (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .ascii             (ascii),
    .ascii_valid       (ascii_valid),
    .speed_up          (speed_up),
    .speed_down        (speed_down),
    .flash_req         (flash_req),
    .flash_rsp         (flash_rsp),
    .sample            (sample),
    .audio_out         (audio_out),
    .sample_valid      (sample_valid),
    .hex0              (hex0),
    .hex1              (hex1),
    .hex2              (hex2),
    .hex3              (hex3)
  );

  // ======================================================================
  // Reference model
  // ======================================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Flash contents mix every address bit
  function automatic flash_word_t flash_word_at(input flash_addr_t a);
    return ({9'd0, a} * 32'h9E3779B1) ^ 32'h13572468;
  endfunction

  function automatic seg7_t seg_pattern(input logic [3:0] nibble);
    return ~SEG_LIT[nibble];
  endfunction

  // k-th sample after a start at the given address and direction
  function automatic sample_t expected_sample(input flash_addr_t start, input logic backward,
                                              input int k);
    int          span;
    int          step;
    flash_addr_t a;
    flash_word_t w;
    logic        upper;
    span = int'(ADDR_LAST) + 1;
    step = (k / 2) % span;
    if (backward)
      a = flash_addr_t'((int'(start) + span - step) % span);
    else
      a = flash_addr_t'((int'(start) + step) % span);
    w     = flash_word_at(a);
    upper = backward ? (k % 2 == 0) : (k % 2 == 1);
    return upper ? w[31:16] : w[15:0];
  endfunction

  // ======================================================================
  // Checking
  // ======================================================================

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      abort_run($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, actual,
                          expected));
  endtask

  always @(posedge CLK_50M)
  begin : compare_samples
    sample_t exp_sample;
    if (!speed_reset_event)
    begin
      if (quiet)
        check_value("sample_valid", sample_valid, 1'b0);
      else if (sample_valid)
      begin
        exp_sample = expected_sample(seq_start, seq_backward, seq_index);
        check_value("sample", sample, exp_sample);
        check_value("audio_out", audio_out, exp_sample[15:8]);
        seq_index = seq_index + 1;
      end
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout, test still running after %0d cycles", cycle_count));
    else if (i_simple_ipod_top.i_flash_playback.i_ipod_assertions.failures != 0)
      abort_run("An assertion bound into flash_playback failed");
  end

  // ======================================================================
  // Flash model
  // ======================================================================

  always @(posedge CLK_50M)
  begin : flash_model
    flash_rsp_t next_rsp;
    next_rsp               = flash_rsp;
    next_rsp.readdatavalid = 1'b0;
    if (speed_reset_event)
    begin
      flash_busy           = 1'b0;
      next_rsp.waitrequest = 1'b1;
    end
    else if (flash_busy)
    begin
      if (latency_left == 0)
      begin
        flash_busy             = 1'b0;
        next_rsp.readdatavalid = 1'b1;
        next_rsp.readdata      = flash_word_at(pending_addr);
      end
      else
        latency_left = latency_left - 1;
    end
    else if (flash_req.read)
    begin
      // Read taken on this edge
      if (!flash_rsp.waitrequest)
      begin
        flash_busy           = 1'b1;
        pending_addr         = flash_req.address;
        lcg_state            = lcg_next(lcg_state);
        latency_left         = int'(lcg_state[25:24]);
        lcg_state            = lcg_next(lcg_state);
        stall_left           = int'(lcg_state[25:24]);
        next_rsp.waitrequest = 1'b1;
      end
      else if (stall_left == 0)
        next_rsp.waitrequest = 1'b0;
      else
        stall_left = stall_left - 1;
    end
    #1;
    flash_rsp = next_rsp;
  end

  // ======================================================================
  // Stimulus
  // ======================================================================

  task automatic send_key(input ascii_t code);
    @(posedge CLK_50M);
    #1;
    ascii       = code;
    ascii_valid = 1'b1;
    @(posedge CLK_50M);
    #1;
    ascii_valid = 1'b0;
  endtask

  // Late samples from before the pause still get checked
  task automatic pause_and_drain(input ascii_t code);
    send_key(code);
    repeat (4) @(posedge CLK_50M);
    #1;
  endtask

  task automatic start_sequence(input flash_addr_t start, input logic backward);
    seq_start    = start;
    seq_backward = backward;
    seq_index    = 0;
  endtask

  task automatic wait_samples(input int count);
    int target;
    target = seq_index + count;
    while (seq_index < target)
    begin
      @(posedge CLK_50M);
      #1;
    end
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) @(posedge CLK_50M);
    #1;
  endtask

  // Key high for exactly wraps repeat periods
  task automatic hold_speed_key(input logic faster, input int wraps);
    int i;
    @(posedge CLK_50M);
    #1;
    speed_up   = faster;
    speed_down = !faster;
    repeat (wraps * REPEAT_CYCLES) @(posedge CLK_50M);
    #1;
    speed_up   = 1'b0;
    speed_down = 1'b0;
    for (i = 0; i < wraps; i++)
    begin
      if (faster && model_divisor > MIN_DIVISOR)
        model_divisor = model_divisor - 16'd1;
      else if (!faster && model_divisor != 16'hFFFF)
        model_divisor = model_divisor + 16'd1;
    end
  endtask

  task automatic pulse_reset();
    @(posedge CLK_50M);
    #1;
    reset_pulse = 1'b1;
    repeat (2) @(posedge CLK_50M);
    #1;
    reset_pulse   = 1'b0;
    model_divisor = DEFAULT_DIVISOR;
  endtask

  task automatic check_display(input divisor_t d);
    repeat (3) @(posedge CLK_50M);
    #1;
    check_value("hex0", hex0, seg_pattern(d[3:0]));
    check_value("hex1", hex1, seg_pattern(d[7:4]));
    check_value("hex2", hex2, seg_pattern(d[11:8]));
    check_value("hex3", hex3, seg_pattern(d[15:12]));
  endtask

  initial
  begin
    ascii         = '0;
    ascii_valid   = 1'b0;
    speed_up      = 1'b0;
    speed_down    = 1'b0;
    reset_pulse   = 1'b0;
    quiet         = 1'b1;
    model_divisor = DEFAULT_DIVISOR;
    start_sequence('0, 1'b0);
    @(negedge power_on_reset);

    // Quiet after reset with the display at 0028
    idle_cycles(QUIET_CYCLES);
    check_display(model_divisor);

    // Forward from address 0 with a wrap
    quiet = 1'b0;
    send_key("E");
    send_key("F");
    wait_samples(N_FWD);

    // Backward from the last address
    pause_and_drain("D");
    send_key("B");
    send_key("R");
    start_sequence(ADDR_LAST, 1'b1);
    send_key("E");
    wait_samples(N_BWD);

    // Lowercase pause, junk codes, resume in place
    pause_and_drain("d");
    quiet = 1'b1;
    send_key("X");
    send_key(8'h00);
    send_key("a");
    idle_cycles(QUIET_CYCLES);
    quiet = 1'b0;
    send_key("e");
    wait_samples(N_RESUME);
    pause_and_drain("d");
    send_key("f");
    send_key("r");
    start_sequence('0, 1'b0);
    send_key("e");
    wait_samples(N_LOWER);

    // Junk while playing
    send_key("Q");
    send_key(8'hFF);
    send_key("1");
    wait_samples(N_JUNK);

    // Speed keys, clamp and reset
    pause_and_drain("D");
    quiet = 1'b1;
    hold_speed_key(1'b1, 5);
    check_display(model_divisor);
    hold_speed_key(1'b1, 40);
    check_display(model_divisor);
    hold_speed_key(1'b0, 3);
    check_display(model_divisor);
    pulse_reset();
    check_display(model_divisor);

    if (i_simple_ipod_top.i_flash_playback.i_ipod_assertions.failures == 0)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
      abort_run("Assertion failures were recorded");
  end

endmodule

//--- bench/ipod_tb_clock.sv
`timescale 1ns/1ps

module ipod_tb_clock
#(
  parameter int RESET_CYCLES = 8
)
(
  output logic CLK_50M,
  output logic power_on_reset
);

  // 50 MHz, 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Released just after an edge, like the other stimulus
  initial
  begin
    power_on_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK_50M);
    #1;
    power_on_reset = 1'b0;
  end

endmodule

//--- verilog.f
verilog/ipod_pkg.sv
verilog/kbd_command_decode.sv
verilog/speed_control.sv
verilog/flash_playback.sv
verilog/player_outputs.sv
verilog/simple_ipod_top.sv
bench/ipod_tb_clock.sv
bench/ipod_assertions.sv
bench/ipod_tb.sv

//--- verilog/flash_playback.sv
`timescale 1ns/1ps

module flash_playback
  import ipod_pkg::*;
#(
  parameter flash_addr_t ADDR_LAST = 23'h7FFFF
)
(
  input  logic        CLK_50M,
  input  logic        speed_reset_event,
  input  play_mode_t  mode,
  input  logic        restart,
  input  logic        sample_tick,
  output flash_req_t  flash_req,
  input  flash_rsp_t  flash_rsp,
  output sample_sel_t sample_sel
);

  play_state_e state;
  flash_addr_t addr;
  flash_addr_t start_addr;
  flash_addr_t step_addr;
  flash_word_t word;
  logic        word_backward;
  logic        restart_pending;
  logic        tick_go;

  assign tick_go    = sample_tick & mode.playing;
  assign start_addr = mode.backward ? ADDR_LAST : '0;

  // Next word address, direction taken from the word just played
  always_comb
  begin
    if (word_backward)
      step_addr = (addr == '0) ? ADDR_LAST : addr - 23'd1;
    else
      step_addr = (addr == ADDR_LAST) ? '0 : addr + 23'd1;
  end

  // ==================================================================
  // Playback FSM
  // ==================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      state           <= PS_IDLE;
      addr            <= '0;
      word_backward   <= 1'b0;
      restart_pending <= 1'b0;
    end
    else
    begin
      case (state)
        PS_IDLE:
        begin
          if (restart)
          begin
            addr  <= start_addr;
            state <= PS_REQUEST;
          end
          else if (tick_go)
            state <= PS_REQUEST;
        end
        PS_REQUEST:
        begin
          // Address must stay put, so a restart waits for the data
          if (restart)
            restart_pending <= 1'b1;
          if (!flash_rsp.waitrequest)
            state <= PS_WAIT_DATA;
        end
        PS_WAIT_DATA:
        begin
          if (restart)
            restart_pending <= 1'b1;
          if (flash_rsp.readdatavalid)
          begin
            if (restart_pending || restart)
            begin
              restart_pending <= 1'b0;
              addr            <= start_addr;
              state           <= PS_REQUEST;
            end
            else
            begin
              word_backward <= mode.backward;
              state         <= PS_FIRST_HALF;
            end
          end
        end
        PS_FIRST_HALF:
        begin
          if (restart)
          begin
            addr  <= start_addr;
            state <= PS_REQUEST;
          end
          else if (mode.playing)
            state <= PS_SECOND_HALF;
        end
        PS_SECOND_HALF:
        begin
          if (restart)
          begin
            addr  <= start_addr;
            state <= PS_REQUEST;
          end
          else if (tick_go)
          begin
            addr  <= step_addr;
            state <= PS_IDLE;
          end
        end
        default: state <= PS_IDLE;
      endcase
    end
  end

  // Fetched word
  always_ff @(posedge CLK_50M)
  begin
    if (state == PS_WAIT_DATA && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

  assign flash_req.read    = (state == PS_REQUEST);
  assign flash_req.address = addr;

  // Backward words play the upper half first
  always_comb
  begin
    sample_sel.word = word;
    if (state == PS_FIRST_HALF)
    begin
      sample_sel.upper_half = word_backward;
      sample_sel.load       = mode.playing & ~restart;
    end
    else
    begin
      sample_sel.upper_half = ~word_backward;
      sample_sel.load       = (state == PS_SECOND_HALF) & tick_go & ~restart;
    end
  end

endmodule

//--- verilog/ipod_pkg.sv
package ipod_pkg;

  // ==================================================================
  // Basic data types
  // ==================================================================

  typedef logic [7:0]  ascii_t;
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic signed [15:0] sample_t;
  typedef logic [15:0] divisor_t;

  // Active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0]  seg7_t;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_PLAY,
    CMD_PAUSE,
    CMD_FORWARD,
    CMD_BACKWARD,
    CMD_RESTART
  } kbd_cmd_e;

  typedef enum logic [2:0] {
    PS_IDLE,
    PS_REQUEST,
    PS_WAIT_DATA,
    PS_FIRST_HALF,
    PS_SECOND_HALF
  } play_state_e;

  // ==================================================================
  // Bundles between blocks
  // ==================================================================

  typedef struct packed {
    logic playing;
    logic backward;
  } play_mode_t;

  // Flash read request, held until waitrequest drops
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  typedef struct packed {
    flash_word_t word;
    logic        upper_half;
    logic        load;
  } sample_sel_t;

  // Keyboard command codes, both cases
  localparam ascii_t ASCII_E_UPPER = 8'h45;
  localparam ascii_t ASCII_E_LOWER = 8'h65;
  localparam ascii_t ASCII_D_UPPER = 8'h44;
  localparam ascii_t ASCII_D_LOWER = 8'h64;
  localparam ascii_t ASCII_F_UPPER = 8'h46;
  localparam ascii_t ASCII_F_LOWER = 8'h66;
  localparam ascii_t ASCII_B_UPPER = 8'h42;
  localparam ascii_t ASCII_B_LOWER = 8'h62;
  localparam ascii_t ASCII_R_UPPER = 8'h52;
  localparam ascii_t ASCII_R_LOWER = 8'h72;

endpackage

//--- verilog/kbd_command_decode.sv
`timescale 1ns/1ps

module kbd_command_decode
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       speed_reset_event,
  input  ascii_t     ascii,
  input  logic       ascii_valid,
  output play_mode_t mode,
  output logic       restart
);

  kbd_cmd_e cmd;

  // Map a character to a command, case insensitive
  function automatic kbd_cmd_e decode_cmd(input ascii_t code);
    kbd_cmd_e result;
    case (code)
      ASCII_E_UPPER, ASCII_E_LOWER: result = CMD_PLAY;
      ASCII_D_UPPER, ASCII_D_LOWER: result = CMD_PAUSE;
      ASCII_F_UPPER, ASCII_F_LOWER: result = CMD_FORWARD;
      ASCII_B_UPPER, ASCII_B_LOWER: result = CMD_BACKWARD;
      ASCII_R_UPPER, ASCII_R_LOWER: result = CMD_RESTART;
      default:                      result = CMD_NONE;
    endcase
    return result;
  endfunction

  assign cmd = decode_cmd(ascii);

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      // Paused, forward
      mode    <= '0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (ascii_valid)
      begin
        case (cmd)
          CMD_PLAY:     mode.playing  <= 1'b1;
          CMD_PAUSE:    mode.playing  <= 1'b0;
          CMD_FORWARD:  mode.backward <= 1'b0;
          CMD_BACKWARD: mode.backward <= 1'b1;
          CMD_RESTART:  restart       <= 1'b1;
          // Anything else leaves the mode alone
          default:      restart       <= 1'b0;
        endcase
      end
    end
  end

endmodule

//--- verilog/player_outputs.sv
`timescale 1ns/1ps

module player_outputs
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        speed_reset_event,
  input  sample_sel_t sample_sel,
  input  divisor_t    divisor,
  output sample_t     sample,
  output ascii_t      audio_out,
  output logic        sample_valid,
  output seg7_t       hex0,
  output seg7_t       hex1,
  output seg7_t       hex2,
  output seg7_t       hex3
);

  // Hex glyph, active low, segment a in bit 0
  function automatic seg7_t hex_glyph(input logic [3:0] nibble);
    seg7_t on;
    case (nibble)
      4'h0: on = 7'h3F;
      4'h1: on = 7'h06;
      4'h2: on = 7'h5B;
      4'h3: on = 7'h4F;
      4'h4: on = 7'h66;
      4'h5: on = 7'h6D;
      4'h6: on = 7'h7D;
      4'h7: on = 7'h07;
      4'h8: on = 7'h7F;
      4'h9: on = 7'h6F;
      4'hA: on = 7'h77;
      4'hB: on = 7'h7C;
      4'hC: on = 7'h39;
      4'hD: on = 7'h5E;
      4'hE: on = 7'h79;
      default: on = 7'h71;
    endcase
    return ~on;
  endfunction

  // ==================================================================
  // Sample path
  // ==================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (sample_sel.load)
    begin
      if (sample_sel.upper_half)
        sample <= sample_sel.word[31:16];
      else
        sample <= sample_sel.word[15:0];
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      sample_valid <= 1'b0;
    else
      sample_valid <= sample_sel.load;
  end

  // Signed 8-bit audio is the top byte
  assign audio_out = sample[15:8];

  // ==================================================================
  // Divisor display
  // ==================================================================

  always_ff @(posedge CLK_50M)
  begin
    hex0 <= hex_glyph(divisor[3:0]);
    hex1 <= hex_glyph(divisor[7:4]);
    hex2 <= hex_glyph(divisor[11:8]);
    hex3 <= hex_glyph(divisor[15:12]);
  end

endmodule

//--- verilog/simple_ipod_top.sv
`timescale 1ns/1ps

module simple_ipod_top
  import ipod_pkg::*;
#(
  parameter flash_addr_t ADDR_LAST       = 23'h7FFFF,
  parameter divisor_t    DEFAULT_DIVISOR = 16'd2272,
  parameter divisor_t    MIN_DIVISOR     = 16'd4,
  parameter int unsigned REPEAT_CYCLES   = 5_000_000
)
(
  input  logic       CLK_50M,
  input  logic       speed_reset_event,
  input  ascii_t     ascii,
  input  logic       ascii_valid,
  input  logic       speed_up,
  input  logic       speed_down,
  output flash_req_t flash_req,
  input  flash_rsp_t flash_rsp,
  output sample_t    sample,
  output ascii_t     audio_out,
  output logic       sample_valid,
  output seg7_t      hex0,
  output seg7_t      hex1,
  output seg7_t      hex2,
  output seg7_t      hex3
);

  play_mode_t  mode;
  logic        restart;
  logic        sample_tick;
  divisor_t    divisor;
  sample_sel_t sample_sel;

  kbd_command_decode i_kbd_command_decode (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .ascii             (ascii),
    .ascii_valid       (ascii_valid),
    .mode              (mode),
    .restart           (restart)
  );

  speed_control #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR),
    .MIN_DIVISOR     (MIN_DIVISOR),
    .REPEAT_CYCLES   (REPEAT_CYCLES)
  ) i_speed_control (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .speed_up          (speed_up),
    .speed_down        (speed_down),
    .divisor           (divisor),
    .sample_tick       (sample_tick)
  );

  flash_playback #(
    .ADDR_LAST (ADDR_LAST)
  ) i_flash_playback (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .mode              (mode),
    .restart           (restart),
    .sample_tick       (sample_tick),
    .flash_req         (flash_req),
    .flash_rsp         (flash_rsp),
    .sample_sel        (sample_sel)
  );

  player_outputs i_player_outputs (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .sample_sel        (sample_sel),
    .divisor           (divisor),
    .sample            (sample),
    .audio_out         (audio_out),
    .sample_valid      (sample_valid),
    .hex0              (hex0),
    .hex1              (hex1),
    .hex2              (hex2),
    .hex3              (hex3)
  );

endmodule

//--- verilog/speed_control.sv
`timescale 1ns/1ps

module speed_control
  import ipod_pkg::*;
#(
  parameter divisor_t    DEFAULT_DIVISOR = 16'd2272,
  parameter divisor_t    MIN_DIVISOR     = 16'd4,
  parameter int unsigned REPEAT_CYCLES   = 5_000_000
)
(
  input  logic     CLK_50M,
  input  logic     speed_reset_event,
  input  logic     speed_up,
  input  logic     speed_down,
  output divisor_t divisor,
  output logic     sample_tick
);

  localparam int RPT_W = $clog2(REPEAT_CYCLES + 1);

  logic [RPT_W-1:0] rpt_count;
  logic             rpt_wrap;
  divisor_t         tick_count;

  // ==================================================================
  // Key repeat
  // ==================================================================

  assign rpt_wrap = (rpt_count == RPT_W'(REPEAT_CYCLES - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      rpt_count <= '0;
    else if (rpt_wrap)
      rpt_count <= '0;
    else
      rpt_count <= rpt_count + 1'b1;
  end

  // Divisor steps once per repeat period, held inside its range
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      divisor <= DEFAULT_DIVISOR;
    else if (rpt_wrap)
    begin
      if (speed_up && !speed_down && divisor > MIN_DIVISOR)
        divisor <= divisor - 16'd1;
      else if (speed_down && !speed_up && divisor != 16'hFFFF)
        divisor <= divisor + 16'd1;
    end
  end

  // ==================================================================
  // Sample tick
  // ==================================================================

  // Compare with >= so a shrinking divisor never strands the counter
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      tick_count  <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_count >= divisor - 16'd1)
    begin
      tick_count  <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_count  <= tick_count + 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule
